//--- hw/cp_pkg.sv
`default_nettype none

package cp_pkg;

  // column array geometry
  localparam int num_col = 2;
  localparam int instr_width = 32;
  // one instruction lane per column in every read beat
  localparam int phit_size = num_col * instr_width;
  localparam int table_depth = 16;
  localparam int pc_width = $clog2(table_depth);

  // beat k of the image fills entry k of all tables
  localparam int num_beats = table_depth;

  // master side
  localparam int addr_width = 64;
  localparam int len_width = 8;
  localparam int count_width = 32;

  // host side
  localparam int axil_addr_width = 6;
  localparam int axil_data_width = 32;
  localparam int axil_strb_width = axil_data_width / 8;
  localparam logic [1:0] resp_okay = 2'b00;

  // register map, byte offsets
  localparam logic [axil_addr_width-1:0] reg_ap_ctrl = 6'h00;
  localparam logic [axil_addr_width-1:0] reg_gie = 6'h04;
  localparam logic [axil_addr_width-1:0] reg_ier = 6'h08;
  localparam logic [axil_addr_width-1:0] reg_isr = 6'h0c;
  localparam logic [axil_addr_width-1:0] reg_ptr_lo = 6'h10;
  localparam logic [axil_addr_width-1:0] reg_ptr_hi = 6'h14;
  localparam logic [axil_addr_width-1:0] reg_cycles = 6'h18;

  // ap_ctrl bit positions
  localparam int ap_start_bit = 0;
  localparam int ap_done_bit = 1;
  localparam int ap_idle_bit = 2;
  localparam int ap_ready_bit = 3;

  // host to slave
  typedef struct packed {
    logic [axil_addr_width-1:0] awaddr;
    logic                       awvalid;
    logic [axil_data_width-1:0] wdata;
    logic [axil_strb_width-1:0] wstrb;
    logic                       wvalid;
    logic                       bready;
    logic [axil_addr_width-1:0] araddr;
    logic                       arvalid;
    logic                       rready;
  } axil_req_t;

  // slave to host
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       arready;
    logic [axil_data_width-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
  } axil_rsp_t;

  // read address from the loader
  typedef struct packed {
    logic                  arvalid;
    logic [addr_width-1:0] araddr;
    logic [len_width-1:0]  arlen;
  } axi_ar_t;

  // read data from memory
  typedef struct packed {
    logic                 rvalid;
    logic [phit_size-1:0] rdata;
    logic                 rlast;
  } axi_r_t;

  // broadcast to every table, each one picks its own lane
  typedef struct packed {
    logic                 en;
    logic [pc_width-1:0]  addr;
    logic [phit_size-1:0] data;
  } tbl_wr_t;

  // per-column counter steering from the datapath
  typedef struct packed {
    logic                clken;
    logic                load;
    logic                incr;
    logic [pc_width-1:0] load_value;
  } pc_ctrl_t;

endpackage

`default_nettype wire

//--- hw/ctrl_regs.sv
`default_nettype none

module ctrl_regs (
  input  logic                                 ap_clk,
  input  logic                                 areset,
  input  cp_pkg::axil_req_t                    axil_req,
  output cp_pkg::axil_rsp_t                    axil_rsp,
  input  logic                                 load_done,
  input  logic [cp_pkg::count_width-1:0]       cycle_count,
  output logic                                 load_start,
  output logic [cp_pkg::addr_width-1:0]        instr_ptr,
  output logic                                 ap_done,
  output logic                                 interrupt
);

  logic                                 wr_hs;
  logic                                 rd_hs;
  logic                                 start_req;
  logic                                 bvalid_q;
  logic                                 rvalid_q;
  logic [cp_pkg::axil_data_width-1:0]   rdata_q;
  logic [cp_pkg::axil_data_width-1:0]   rd_word;
  logic                                 start_q;
  logic                                 done_q;
  logic                                 idle_q;
  logic                                 load_start_q;
  logic                                 gie_q;
  logic                                 ier_q;
  logic                                 isr_q;
  logic [cp_pkg::axil_data_width-1:0]   ptr_lo_q;
  logic [cp_pkg::axil_data_width-1:0]   ptr_hi_q;
  logic [cp_pkg::count_width-1:0]       cycles_q;

  // merge only the enabled byte lanes into the old value
  function automatic logic [cp_pkg::axil_data_width-1:0] apply_wstrb(
    input logic [cp_pkg::axil_data_width-1:0] old_val,
    input logic [cp_pkg::axil_data_width-1:0] new_val,
    input logic [cp_pkg::axil_strb_width-1:0] strb
  );
    logic [cp_pkg::axil_data_width-1:0] res;
    res = old_val;
    for (int b = 0; b < cp_pkg::axil_strb_width; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // address and data accepted together, blocked while a response waits
  assign wr_hs = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
  // one read in flight at a time
  assign rd_hs = axil_req.arvalid & ~rvalid_q;

  assign start_req = wr_hs && (axil_req.awaddr == cp_pkg::reg_ap_ctrl) &&
                     axil_req.wstrb[0] && axil_req.wdata[cp_pkg::ap_start_bit];

  // response channels
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // read data captured with the address
  always_ff @(posedge ap_clk) begin
    if (rd_hs) begin
      rdata_q <= rd_word;
    end
  end

  // ap_ctrl handshake bits
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_q      <= 1'b0;
      done_q       <= 1'b0;
      idle_q       <= 1'b1;
      load_start_q <= 1'b0;
    end else begin
      // start only launches a load from idle
      load_start_q <= start_req & idle_q;
      if (load_done) begin
        start_q <= 1'b0;
        done_q  <= 1'b1;
        idle_q  <= 1'b1;
      end else begin
        if (start_req && idle_q) begin
          start_q <= 1'b1;
          idle_q  <= 1'b0;
        end
        // done is clear-on-read
        if (rd_hs && (axil_req.araddr == cp_pkg::reg_ap_ctrl)) begin
          done_q <= 1'b0;
        end
      end
    end
  end

  // interrupt enables and status
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      gie_q <= 1'b0;
      ier_q <= 1'b0;
      isr_q <= 1'b0;
    end else begin
      if (wr_hs && axil_req.wstrb[0]) begin
        if (axil_req.awaddr == cp_pkg::reg_gie) begin
          gie_q <= axil_req.wdata[0];
        end
        if (axil_req.awaddr == cp_pkg::reg_ier) begin
          ier_q <= axil_req.wdata[0];
        end
      end
      // load completion wins over a host toggle
      if (load_done) begin
        isr_q <= 1'b1;
      end else if (wr_hs && (axil_req.awaddr == cp_pkg::reg_isr) &&
                   axil_req.wstrb[0] && axil_req.wdata[0]) begin
        isr_q <= ~isr_q;
      end
    end
  end

  // instruction pointer and latched cycle count
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ptr_lo_q <= '0;
      ptr_hi_q <= '0;
      cycles_q <= '0;
    end else begin
      if (wr_hs && (axil_req.awaddr == cp_pkg::reg_ptr_lo)) begin
        ptr_lo_q <= apply_wstrb(ptr_lo_q, axil_req.wdata, axil_req.wstrb);
      end
      if (wr_hs && (axil_req.awaddr == cp_pkg::reg_ptr_hi)) begin
        ptr_hi_q <= apply_wstrb(ptr_hi_q, axil_req.wdata, axil_req.wstrb);
      end
      if (load_done) begin
        cycles_q <= cycle_count;
      end
    end
  end

  // read decode
  always_comb begin
    rd_word = '0;
    case (axil_req.araddr)
      cp_pkg::reg_ap_ctrl: begin
        rd_word[cp_pkg::ap_start_bit] = start_q;
        rd_word[cp_pkg::ap_done_bit]  = done_q;
        rd_word[cp_pkg::ap_idle_bit]  = idle_q;
        // ready mirrors done, no pipelining
        rd_word[cp_pkg::ap_ready_bit] = done_q;
      end
      cp_pkg::reg_gie:    rd_word[0] = gie_q;
      cp_pkg::reg_ier:    rd_word[0] = ier_q;
      cp_pkg::reg_isr:    rd_word[0] = isr_q;
      cp_pkg::reg_ptr_lo: rd_word = ptr_lo_q;
      cp_pkg::reg_ptr_hi: rd_word = ptr_hi_q;
      cp_pkg::reg_cycles: rd_word = cycles_q;
      default:            rd_word = '0;
    endcase
  end

  assign axil_rsp.awready = wr_hs;
  assign axil_rsp.wready  = wr_hs;
  assign axil_rsp.bresp   = cp_pkg::resp_okay;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.arready = ~rvalid_q;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = cp_pkg::resp_okay;
  assign axil_rsp.rvalid  = rvalid_q;

  assign load_start = load_start_q;
  assign instr_ptr  = {ptr_hi_q, ptr_lo_q};
  assign ap_done    = done_q;
  assign interrupt  = gie_q & ier_q & isr_q;

endmodule

`default_nettype wire

//--- hw/instr_table.sv
`default_nettype none

module instr_table (
  input  logic                             ap_clk,
  input  logic                             areset,
  input  logic                             wr_en,
  input  logic [cp_pkg::pc_width-1:0]      wr_addr,
  input  logic [cp_pkg::instr_width-1:0]   wr_data,
  input  cp_pkg::pc_ctrl_t                 pc_ctrl,
  output logic [cp_pkg::pc_width-1:0]      pc,
  output logic [cp_pkg::instr_width-1:0]   instr
);

  logic [cp_pkg::instr_width-1:0] mem [cp_pkg::table_depth];
  logic [cp_pkg::pc_width-1:0]    pc_q;
  logic [cp_pkg::pc_width-1:0]    pc_next;
  logic [cp_pkg::instr_width-1:0] instr_q;
  logic                           wr_hit;

  // load beats incr, both need clken
  always_comb begin
    pc_next = pc_q;
    if (pc_ctrl.clken) begin
      if (pc_ctrl.load) begin
        pc_next = pc_ctrl.load_value;
      end else if (pc_ctrl.incr) begin
        // wraps at table_depth
        pc_next = pc_q + 1'b1;
      end
    end
  end

  // write landing on the entry about to be presented
  assign wr_hit = wr_en && (wr_addr == pc_next);

  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  // bypass the write so the output never shows a stale entry
  always_ff @(posedge ap_clk) begin
    if (wr_hit) begin
      instr_q <= wr_data;
    end else if (pc_ctrl.clken) begin
      instr_q <= mem[pc_next];
    end
  end

  assign pc    = pc_q;
  assign instr = instr_q;

endmodule

`default_nettype wire

//--- hw/instr_loader.sv
`default_nettype none

module instr_loader (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  logic                           load_start,
  input  logic [cp_pkg::addr_width-1:0]  instr_ptr,
  output cp_pkg::axi_ar_t                m_axi_ar,
  input  logic                           m_axi_arready,
  input  cp_pkg::axi_r_t                 m_axi_r,
  output logic                           m_axi_rready,
  output cp_pkg::tbl_wr_t                tbl_wr,
  output logic                           load_done,
  output logic [cp_pkg::count_width-1:0] cycle_count
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_t;

  state_t                         state;
  logic [cp_pkg::addr_width-1:0]  araddr_q;
  logic [cp_pkg::pc_width-1:0]    beat_cnt;
  logic [cp_pkg::count_width-1:0] cycles_q;
  logic                           beat_acc;
  logic                           done_q;
  logic                           wr_en_q;
  logic [cp_pkg::pc_width-1:0]    wr_addr_q;
  logic [cp_pkg::phit_size-1:0]   wr_data_q;

  // rready is high for the whole data state
  assign beat_acc = (state == st_data) && m_axi_r.rvalid;

  // idle -> addr -> data -> idle, one burst per start
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          // start while busy never reaches here
          if (load_start) begin
            state <= st_addr;
          end
        end
        st_addr: begin
          if (m_axi_arready) begin
            state <= st_data;
          end
        end
        st_data: begin
          if (beat_acc && m_axi_r.rlast) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // burst address taken at start
  always_ff @(posedge ap_clk) begin
    if ((state == st_idle) && load_start) begin
      araddr_q <= instr_ptr;
    end
  end

  // beat index, cycle count and done strobe
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      beat_cnt <= '0;
      cycles_q <= '0;
      done_q   <= 1'b0;
      wr_en_q  <= 1'b0;
    end else begin
      done_q  <= beat_acc & m_axi_r.rlast;
      wr_en_q <= beat_acc;
      if ((state == st_idle) && load_start) begin
        beat_cnt <= '0;
        cycles_q <= '0;
      end else begin
        if (beat_acc) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        // stalls in either busy state count too
        if (state != st_idle) begin
          cycles_q <= cycles_q + 1'b1;
        end
      end
    end
  end

  // accepted beat lands in the tables a cycle later
  always_ff @(posedge ap_clk) begin
    if (beat_acc) begin
      wr_addr_q <= beat_cnt;
      wr_data_q <= m_axi_r.rdata;
    end
  end

  assign m_axi_ar.arvalid = (state == st_addr);
  assign m_axi_ar.araddr  = araddr_q;
  assign m_axi_ar.arlen   = cp_pkg::len_width'(cp_pkg::num_beats - 1);
  assign m_axi_rready     = (state == st_data);

  assign tbl_wr.en   = wr_en_q;
  assign tbl_wr.addr = wr_addr_q;
  assign tbl_wr.data = wr_data_q;

  assign load_done   = done_q;
  assign cycle_count = cycles_q;

endmodule

`default_nettype wire

//--- hw/control_plane.sv
`default_nettype none

module control_plane (
  input  logic                                                 ap_clk,
  input  logic                                                 ap_rst_n,
  input  cp_pkg::axil_req_t                                    s_axil_req,
  output cp_pkg::axil_rsp_t                                    s_axil_rsp,
  output logic                                                 interrupt,
  output cp_pkg::axi_ar_t                                      m_axi_ar,
  input  logic                                                 m_axi_arready,
  input  cp_pkg::axi_r_t                                       m_axi_r,
  output logic                                                 m_axi_rready,
  input  cp_pkg::pc_ctrl_t [cp_pkg::num_col-1:0]               pc_ctrl,
  output logic [cp_pkg::num_col-1:0][cp_pkg::instr_width-1:0]  instr,
  output logic [cp_pkg::count_width-1:0]                       cycle_register,
  output logic                                                 done_loader
);

  logic                           areset;
  logic                           load_start;
  logic                           load_done;
  logic [cp_pkg::addr_width-1:0]  instr_ptr;
  logic [cp_pkg::count_width-1:0] cycle_count;
  logic                           ap_done;
  cp_pkg::tbl_wr_t                tbl_wr;
  // counters are observable only through the instruction stream
  logic [cp_pkg::num_col-1:0][cp_pkg::pc_width-1:0] pc;

  // internal reset lags ap_rst_n by one cycle
  always_ff @(posedge ap_clk) begin
    areset <= ~ap_rst_n;
  end

  ctrl_regs u_ctrl_regs (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .axil_req    (s_axil_req),
    .axil_rsp    (s_axil_rsp),
    .load_done   (load_done),
    .cycle_count (cycle_count),
    .load_start  (load_start),
    .instr_ptr   (instr_ptr),
    .ap_done     (ap_done),
    .interrupt   (interrupt)
  );

  instr_loader u_instr_loader (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .load_start    (load_start),
    .instr_ptr     (instr_ptr),
    .m_axi_ar      (m_axi_ar),
    .m_axi_arready (m_axi_arready),
    .m_axi_r       (m_axi_r),
    .m_axi_rready  (m_axi_rready),
    .tbl_wr        (tbl_wr),
    .load_done     (load_done),
    .cycle_count   (cycle_count)
  );

  // one table per column, each fed from its own lane of the beat
  for (genvar c = 0; c < cp_pkg::num_col; c++) begin : g_col
    instr_table u_instr_table (
      .ap_clk  (ap_clk),
      .areset  (areset),
      .wr_en   (tbl_wr.en),
      .wr_addr (tbl_wr.addr),
      .wr_data (tbl_wr.data[c*cp_pkg::instr_width +: cp_pkg::instr_width]),
      .pc_ctrl (pc_ctrl[c]),
      .pc      (pc[c]),
      .instr   (instr[c])
    );
  end

  assign cycle_register = cycle_count;
  // sticky done from the register block
  assign done_loader    = ap_done;

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic ap_clk,
  output logic ap_rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 8 ns period
  localparam int half_period = 4;
  localparam int reset_cycles = 16;

  initial begin
    ap_clk = 1'b0;
    forever #(half_period) ap_clk = ~ap_clk;
  end

  // reset released on a falling edge, same as the other inputs
  initial begin
    ap_rst_n = 1'b0;
    repeat (reset_cycles) @(posedge ap_clk);
    @(negedge ap_clk);
    ap_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/tb_control_plane.sv
`default_nettype none

module tb_control_plane;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 8;
  localparam int wait_limit = 1000;
  localparam int nb = cp_pkg::num_beats;
  // rough cycle budget per test
  localparam int axil_op_cycles = 5;
  localparam int load_cycles = 3 * nb + 6 * axil_op_cycles + 10;
  localparam int run_cycles = 24 + 4 * axil_op_cycles + (load_cycles + axil_op_cycles + 10) +
                              (2 * nb + 4) + 10 + (load_cycles + axil_op_cycles + 2 * nb + 4) +
                              (2 * load_cycles + 10 * axil_op_cycles + 10);
  localparam int watchdog_ns = 4 * run_cycles * clk_period;

  logic                                                ap_clk;
  logic                                                ap_rst_n;
  cp_pkg::axil_req_t                                   s_axil_req;
  cp_pkg::axil_rsp_t                                   s_axil_rsp;
  logic                                                interrupt;
  cp_pkg::axi_ar_t                                     m_axi_ar;
  logic                                                m_axi_arready;
  cp_pkg::axi_r_t                                      m_axi_r;
  logic                                                m_axi_rready;
  cp_pkg::pc_ctrl_t [cp_pkg::num_col-1:0]              pc_ctrl;
  logic [cp_pkg::num_col-1:0][cp_pkg::instr_width-1:0] instr;
  logic [cp_pkg::count_width-1:0]                      cycle_register;
  logic                                                done_loader;

  // memory model state
  logic [31:0]                      lfsr_state;
  logic [cp_pkg::phit_size-1:0]     image [nb];
  logic [cp_pkg::addr_width-1:0]    seen_araddr;
  logic [cp_pkg::len_width-1:0]     seen_arlen;
  int                               burst_count = 0;
  logic                             arvalid_prev = 1'b0;

  tb_clock u_clock (
    .ap_clk   (ap_clk),
    .ap_rst_n (ap_rst_n)
  );

  control_plane dut (
    .ap_clk         (ap_clk),
    .ap_rst_n       (ap_rst_n),
    .s_axil_req     (s_axil_req),
    .s_axil_rsp     (s_axil_rsp),
    .interrupt      (interrupt),
    .m_axi_ar       (m_axi_ar),
    .m_axi_arready  (m_axi_arready),
    .m_axi_r        (m_axi_r),
    .m_axi_rready   (m_axi_rready),
    .pc_ctrl        (pc_ctrl),
    .instr          (instr),
    .cycle_register (cycle_register),
    .done_loader    (done_loader)
  );

  // every rising arvalid is a new burst
  always @(negedge ap_clk) begin
    if (m_axi_ar.arvalid && !arvalid_prev) begin
      burst_count++;
    end
    arvalid_prev <= m_axi_ar.arvalid;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // taps of x^32 + x^22 + x^2 + x + 1 in a right shift
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic next_random_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    return b;
  endfunction

  // fresh image with one lfsr step per bit
  task automatic make_image();
    for (int k = 0; k < nb; k++) begin
      for (int b = 0; b < cp_pkg::phit_size; b++) begin
        image[k][b] = next_random_bit();
      end
    end
  endtask

  task automatic axil_write(input logic [cp_pkg::axil_addr_width-1:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
    int waited;
    waited = 0;
    @(negedge ap_clk);
    s_axil_req.awaddr  = addr;
    s_axil_req.awvalid = 1'b1;
    s_axil_req.wdata   = data;
    s_axil_req.wstrb   = strb;
    s_axil_req.wvalid  = 1'b1;
    s_axil_req.bready  = 1'b1;
    // address and data taken together in this cycle
    #1;
    check_value("axil write awready", 64'd1, 64'(s_axil_rsp.awready));
    check_value("axil write wready", 64'd1, 64'(s_axil_rsp.wready));
    // bvalid comes a cycle after the handshake
    do begin
      @(negedge ap_clk);
      waited++;
      if (waited > wait_limit) abort_run("AXI-Lite write got no write response");
    end while (!s_axil_rsp.bvalid);
    check_value("axil write bresp", 64'(cp_pkg::resp_okay), 64'(s_axil_rsp.bresp));
    // ready lasts a single cycle
    check_value("axil write awready held", 64'd0, 64'(s_axil_rsp.awready));
    s_axil_req.awvalid = 1'b0;
    s_axil_req.wvalid  = 1'b0;
    @(negedge ap_clk);
    s_axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [cp_pkg::axil_addr_width-1:0] addr,
                           output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge ap_clk);
    check_value("axil read arready free", 64'd1, 64'(s_axil_rsp.arready));
    s_axil_req.araddr  = addr;
    s_axil_req.arvalid = 1'b1;
    s_axil_req.rready  = 1'b1;
    do begin
      @(negedge ap_clk);
      waited++;
      if (waited > wait_limit) abort_run("AXI-Lite read got no read data");
    end while (!s_axil_rsp.rvalid);
    check_value("axil read rresp", 64'(cp_pkg::resp_okay), 64'(s_axil_rsp.rresp));
    // no second address while data is pending
    check_value("axil read arready busy", 64'd0, 64'(s_axil_rsp.arready));
    data = s_axil_rsp.rdata;
    s_axil_req.arvalid = 1'b0;
    @(negedge ap_clk);
    s_axil_req.rready = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [cp_pkg::axil_addr_width-1:0] addr,
                             input logic [31:0] expected);
    logic [31:0] data;
    axil_read(addr, data);
    check_value(name, 64'(expected), 64'(data));
  endtask

  // same steering on every column
  task automatic set_pc_ctrl(input logic clken, input logic load, input logic incr,
                             input logic [cp_pkg::pc_width-1:0] value);
    for (int c = 0; c < cp_pkg::num_col; c++) begin
      pc_ctrl[c].clken      = clken;
      pc_ctrl[c].load       = load;
      pc_ctrl[c].incr       = incr;
      pc_ctrl[c].load_value = value;
    end
  endtask

  // counter at entry k and instr from lane c of beat k
  task automatic check_lanes(input string name, input int k);
    for (int c = 0; c < cp_pkg::num_col; c++) begin
      check_value($sformatf("%s pc col %0d", name, c), 64'(k), 64'(dut.pc[c]));
      check_value($sformatf("%s instr col %0d entry %0d", name, c, k),
                  64'(image[k][c*cp_pkg::instr_width +: cp_pkg::instr_width]), 64'(instr[c]));
    end
  endtask

  // memory side of one burst with stalls picked per cycle
  task automatic serve_burst(input logic stall_en, output int stalls);
    int   waited;
    logic stall;
    stalls = 0;
    waited = 0;
    while (!m_axi_ar.arvalid) begin
      @(negedge ap_clk);
      waited++;
      if (waited > wait_limit) abort_run("loader issued no read address");
    end
    seen_araddr = m_axi_ar.araddr;
    seen_arlen  = m_axi_ar.arlen;
    do begin
      stall = stall_en ? next_random_bit() : 1'b0;
      m_axi_arready = ~stall;
      if (stall) stalls++;
      @(negedge ap_clk);
    end while (stall);
    m_axi_arready = 1'b0;
    for (int k = 0; k < nb; k++) begin
      do begin
        stall = stall_en ? next_random_bit() : 1'b0;
        m_axi_r.rvalid = ~stall;
        m_axi_r.rdata  = image[k];
        m_axi_r.rlast  = (k == nb - 1);
        if (stall) stalls++;
        if (!m_axi_rready) abort_run("loader rready low during the data phase");
        @(negedge ap_clk);
      end while (stall);
    end
    m_axi_r = '0;
  endtask

  task automatic run_load(input string name, input logic [63:0] ptr, input logic stall_en,
                          output int stalls);
    int waited;
    waited = 0;
    make_image();
    axil_write(cp_pkg::reg_ptr_lo, ptr[31:0], 4'hf);
    axil_write(cp_pkg::reg_ptr_hi, ptr[63:32], 4'hf);
    axil_write(cp_pkg::reg_ap_ctrl, 32'h1, 4'h1);
    serve_burst(stall_en, stalls);
    while (!done_loader) begin
      @(negedge ap_clk);
      waited++;
      if (waited > wait_limit) abort_run("done_loader never rose after the burst");
    end
    // done idle and ready set while start is clear
    read_expect({name, " ap_ctrl"}, cp_pkg::reg_ap_ctrl, 32'h0000_000e);
  endtask

  task automatic reset_state_and_wstrb();
    // only idle after reset
    read_expect("reset ap_ctrl", cp_pkg::reg_ap_ctrl, 32'h0000_0004);
    check_value("reset interrupt", 64'd0, 64'(interrupt));
    check_value("reset arvalid", 64'd0, 64'(m_axi_ar.arvalid));
    check_value("reset rready", 64'd0, 64'(m_axi_rready));
    axil_write(cp_pkg::reg_ptr_lo, 32'h1122_3344, 4'hf);
    axil_write(cp_pkg::reg_ptr_lo, 32'haabb_ccdd, 4'b0101);
    // bytes 0 and 2 replaced
    read_expect("wstrb ptr_lo", cp_pkg::reg_ptr_lo, 32'h11bb_33dd);
  endtask

  task automatic single_load_burst();
    int stalls;
    int bursts_before;
    bursts_before = burst_count;
    run_load("single load", 64'h0000_0040_8000_1000, 1'b0, stalls);
    check_value("burst araddr", 64'h0000_0040_8000_1000, seen_araddr);
    check_value("burst arlen", 64'(nb - 1), 64'(seen_arlen));
    // done cleared by the previous read
    read_expect("second ap_ctrl", cp_pkg::reg_ap_ctrl, 32'h0000_0004);
    check_value("done_loader cleared", 64'd0, 64'(done_loader));
    repeat (8) @(negedge ap_clk);
    check_value("burst count", 64'd1, 64'(burst_count - bursts_before));
    check_value("stall free cycles", 64'(nb + 1), 64'(cycle_register));
  endtask

  // every fourth entry by load and the rest by incr
  task automatic walk_tables(input string name);
    for (int k = 0; k < nb; k++) begin
      @(negedge ap_clk);
      set_pc_ctrl(1'b1, (k % 4) == 0, (k % 4) != 0, cp_pkg::pc_width'(k));
      @(negedge ap_clk);
      set_pc_ctrl(1'b0, 1'b0, 1'b0, '0);
      check_lanes(name, k);
    end
  endtask

  task automatic pc_hold_and_priority();
    @(negedge ap_clk);
    set_pc_ctrl(1'b1, 1'b1, 1'b0, 4'd5);
    @(negedge ap_clk);
    // strobes ignored without clken
    set_pc_ctrl(1'b0, 1'b1, 1'b1, 4'd9);
    repeat (3) begin
      @(negedge ap_clk);
      check_lanes("clken low", 5);
    end
    set_pc_ctrl(1'b1, 1'b1, 1'b1, 4'd9);
    @(negedge ap_clk);
    set_pc_ctrl(1'b0, 1'b0, 1'b0, '0);
    check_lanes("load over incr", 9);
  endtask

  task automatic stalled_load_count();
    int stalls;
    run_load("stalled load", 64'h0000_0000_0002_3400, 1'b1, stalls);
    check_value("burst araddr stalled", 64'h0000_0000_0002_3400, seen_araddr);
    // one address cycle plus one per beat plus every stall
    check_value("cycle output", 64'(nb + stalls + 1), 64'(cycle_register));
    read_expect("cycle register", cp_pkg::reg_cycles, 32'(nb + stalls + 1));
    walk_tables("stalled tables");
  endtask

  task automatic interrupt_enables();
    int stalls;
    // earlier loads left isr set
    read_expect("isr before", cp_pkg::reg_isr, 32'h1);
    axil_write(cp_pkg::reg_isr, 32'h1, 4'h1);
    read_expect("isr toggled", cp_pkg::reg_isr, 32'h0);
    axil_write(cp_pkg::reg_gie, 32'h1, 4'h1);
    axil_write(cp_pkg::reg_ier, 32'h1, 4'h1);
    check_value("irq idle", 64'd0, 64'(interrupt));
    run_load("irq load", 64'h0000_0001_0000_0800, 1'b0, stalls);
    check_value("irq raised", 64'd1, 64'(interrupt));
    axil_write(cp_pkg::reg_isr, 32'h1, 4'h1);
    check_value("irq cleared", 64'd0, 64'(interrupt));
    // source masked off
    axil_write(cp_pkg::reg_ier, 32'h0, 4'h1);
    run_load("masked load", 64'h0000_0001_0000_4000, 1'b0, stalls);
    repeat (4) begin
      @(negedge ap_clk);
      check_value("irq masked", 64'd0, 64'(interrupt));
    end
    read_expect("masked isr", cp_pkg::reg_isr, 32'h1);
  endtask

  initial begin
    s_axil_req    = '0;
    m_axi_arready = 1'b0;
    m_axi_r       = '0;
    pc_ctrl       = '0;
    lfsr_state    = 32'hbcc5;
    wait (ap_rst_n === 1'b1);
    // internal reset trails ap_rst_n
    repeat (3) @(negedge ap_clk);
    reset_state_and_wstrb();
    single_load_burst();
    walk_tables("table contents");
    pc_hold_and_priority();
    stalled_load_count();
    interrupt_enables();
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    abort_run($sformatf("watchdog expired after %0d ns, tests did not finish", watchdog_ns));
  end

endmodule

`default_nettype wire

//--- sim.f
hw/cp_pkg.sv
hw/ctrl_regs.sv
hw/instr_table.sv
hw/instr_loader.sv
hw/control_plane.sv
verification/tb_clock.sv
verification/tb_control_plane.sv

//--- Makefile
SOURCES := $(shell cat sim.f)

obj_dir/Vtb_control_plane: sim.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps -f sim.f \
	  --top-module tb_control_plane -o Vtb_control_plane

.PHONY: run clean

run: obj_dir/Vtb_control_plane
	@out="$$(./obj_dir/Vtb_control_plane 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
